// ==== Bender.yml ====
package:
  name: issue_backend

sources:
  - design/issue_pkg.sv
  - design/regfile.sv
  - design/alu_unit.sv
  - design/scoreboard.sv
  - design/issue_read_operands.sv
  - design/issue_stage.sv
  - design/backend_top.sv
  - target: test
    files:
      - tests/tb_backend.sv

// ==== compile.f ====
design/issue_pkg.sv
design/regfile.sv
design/alu_unit.sv
design/scoreboard.sv
design/issue_read_operands.sv
design/issue_stage.sv
design/backend_top.sv
tests/tb_backend.sv

// ==== design/alu_unit.sv ====
// Single-cycle ALU, result registered and returned with its transaction ID
module alu_unit
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  logic                     fu_valid_i,
  input  fu_data_t                 fu_data_i,
  output logic                     wb_valid_o,
  output logic [TRANS_ID_BITS-1:0] wb_trans_id_o,
  output logic [XLEN-1:0]          wb_data_o
);

  logic [XLEN-1:0] result;

  // --------------------
  // Datapath
  // --------------------
  // All results wrap modulo 2**XLEN
  always_comb begin
    unique case (fu_data_i.op)
      ALU_ADD: result = fu_data_i.operand_a + fu_data_i.operand_b;
      ALU_SUB: result = fu_data_i.operand_a - fu_data_i.operand_b;
      ALU_AND: result = fu_data_i.operand_a & fu_data_i.operand_b;
      ALU_OR:  result = fu_data_i.operand_a | fu_data_i.operand_b;
      ALU_XOR: result = fu_data_i.operand_a ^ fu_data_i.operand_b;
      ALU_SLL: result = fu_data_i.operand_a << fu_data_i.operand_b[3:0];
      default: result = '0;
    endcase
  end

  // --------------------
  // Writeback register
  // --------------------
  // Flush kills a result still in flight
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= fu_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fu_valid_i) begin
      wb_trans_id_o <= fu_data_i.trans_id;
      wb_data_o     <= result;
    end
  end

endmodule

// ==== design/backend_top.sv ====
// Back end top: issue stage, register file and ALU behind a decode and a commit port
module backend_top
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // Decode handshake, one field per port
  input  logic                     instr_valid_i,
  input  alu_op_e                  instr_op_i,
  input  logic [REG_ADDR_SIZE-1:0] instr_rd_i,
  input  logic [REG_ADDR_SIZE-1:0] instr_rs1_i,
  input  logic [REG_ADDR_SIZE-1:0] instr_rs2_i,
  input  logic [IMM_BITS-1:0]      instr_imm_i,
  input  logic                     instr_use_imm_i,
  output logic                     instr_ack_o,
  // Commit
  output logic                     commit_valid_o,
  output logic [REG_ADDR_SIZE-1:0] commit_rd_o,
  output logic [XLEN-1:0]          commit_data_o,
  input  logic                     commit_ack_i
);

  decoded_instr_t           instr;
  logic [REG_ADDR_SIZE-1:0] rs1;
  logic [REG_ADDR_SIZE-1:0] rs2;
  logic [XLEN-1:0]          rf_rdata1;
  logic [XLEN-1:0]          rf_rdata2;
  logic                     fu_valid;
  fu_data_t                 fu_data;
  logic                     wb_valid;
  logic [TRANS_ID_BITS-1:0] wb_trans_id;
  logic [XLEN-1:0]          wb_data;
  logic                     rf_we;

  // Pack decode fields
  assign instr.op      = instr_op_i;
  assign instr.rd      = instr_rd_i;
  assign instr.rs1     = instr_rs1_i;
  assign instr.rs2     = instr_rs2_i;
  assign instr.imm     = instr_imm_i;
  assign instr.use_imm = instr_use_imm_i;

  // Register file is written on every accepted commit
  assign rf_we = commit_valid_o && commit_ack_i;

  // --------------------
  // Issue stage
  // --------------------
  issue_stage i_issue_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr),
    .instr_ack_o    (instr_ack_o),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rf_rdata1_i    (rf_rdata1),
    .rf_rdata2_i    (rf_rdata2),
    .fu_valid_o     (fu_valid),
    .fu_data_o      (fu_data),
    .wb_valid_i     (wb_valid),
    .wb_trans_id_i  (wb_trans_id),
    .wb_data_i      (wb_data),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o),
    .commit_ack_i   (commit_ack_i)
  );

  // --------------------
  // Register file and ALU
  // --------------------
  regfile i_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .we_i     (rf_we),
    .waddr_i  (commit_rd_o),
    .wdata_i  (commit_data_o)
  );

  alu_unit i_alu_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .fu_valid_i    (fu_valid),
    .fu_data_i     (fu_data),
    .wb_valid_o    (wb_valid),
    .wb_trans_id_o (wb_trans_id),
    .wb_data_o     (wb_data)
  );

endmodule

// ==== design/issue_pkg.sv ====
// Shared widths, ALU operation codes and pipeline structs, imported by every back end module
package issue_pkg;

  // --------------------
  // Widths and depths
  // --------------------
  // Datapath width of the toy core
  localparam int unsigned XLEN          = 16;
  localparam int unsigned REG_ADDR_SIZE = 3;
  localparam int unsigned NR_REGS       = 8;
  // Ring depth, equal to 2**TRANS_ID_BITS so pointers wrap on their own
  localparam int unsigned NR_SB_ENTRIES = 4;
  localparam int unsigned TRANS_ID_BITS = 2;
  // One extra bit so a full ring can be told from an empty one
  localparam int unsigned SB_CNT_BITS   = TRANS_ID_BITS + 1;
  // Immediate is zero-extended to XLEN at dispatch
  localparam int unsigned IMM_BITS      = 8;

  // --------------------
  // ALU operations
  // --------------------
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    // Shift amount is the low 4 bits of operand b
    ALU_SLL
  } alu_op_e;

  // --------------------
  // Pipeline structs
  // --------------------
  // Instruction as delivered by decode
  typedef struct packed {
    alu_op_e                  op;
    logic [REG_ADDR_SIZE-1:0] rd;
    logic [REG_ADDR_SIZE-1:0] rs1;
    logic [REG_ADDR_SIZE-1:0] rs2;
    logic [IMM_BITS-1:0]      imm;
    logic                     use_imm;
  } decoded_instr_t;

  // One slot of the scoreboard ring
  typedef struct packed {
    decoded_instr_t  instr;
    logic            issued;
    logic            finished;
    logic [XLEN-1:0] result;
  } sb_entry_t;

  // Operation handed to the ALU, tagged with its ring slot
  typedef struct packed {
    alu_op_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

endpackage

// ==== design/issue_read_operands.sv ====
// Resolves operands for the issuing instruction and registers the dispatch to the ALU
module issue_read_operands
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // From the scoreboard
  input  decoded_instr_t           issue_instr_i,
  input  logic [TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic                     issue_valid_i,
  output logic                     issue_ack_o,
  // Source addresses, shared by scoreboard lookup and register file
  output logic [REG_ADDR_SIZE-1:0] rs1_o,
  output logic [REG_ADDR_SIZE-1:0] rs2_o,
  // Forwarding answers
  input  logic                     rs1_clobber_i,
  input  logic                     rs2_clobber_i,
  input  logic                     rs1_fwd_valid_i,
  input  logic                     rs2_fwd_valid_i,
  input  logic [XLEN-1:0]          rs1_fwd_i,
  input  logic [XLEN-1:0]          rs2_fwd_i,
  // Register file data
  input  logic [XLEN-1:0]          rf_rdata1_i,
  input  logic [XLEN-1:0]          rf_rdata2_i,
  // To the ALU
  output logic                     fu_valid_o,
  output fu_data_t                 fu_data_o
);

  logic            rs1_ready;
  logic            rs2_ready;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] rs2_value;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] imm_ext;
  fu_data_t        fu_data_q;
  logic            fu_valid_q;

  assign rs1_o = issue_instr_i.rs1;
  assign rs2_o = issue_instr_i.rs2;

  // --------------------
  // Operand selection
  // --------------------
  // Clobbered and finished means forward, clobbered and pending means RAW stall
  assign rs1_ready = !rs1_clobber_i || rs1_fwd_valid_i;
  assign operand_a = rs1_clobber_i ? rs1_fwd_i : rf_rdata1_i;

  // rs2 only matters without an immediate
  assign rs2_ready = issue_instr_i.use_imm || !rs2_clobber_i || rs2_fwd_valid_i;
  assign rs2_value = rs2_clobber_i ? rs2_fwd_i : rf_rdata2_i;

  assign imm_ext   = {{(XLEN - IMM_BITS){1'b0}}, issue_instr_i.imm};
  assign operand_b = issue_instr_i.use_imm ? imm_ext : rs2_value;

  // ALU is always ready, so only the operands hold back issue
  assign issue_ack_o = issue_valid_i && rs1_ready && rs2_ready;

  // --------------------
  // Dispatch register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      fu_valid_q <= 1'b0;
    end else begin
      fu_valid_q <= issue_ack_o;
    end
  end

  // Operation and operands captured on dispatch
  always_ff @(posedge clk_i) begin
    if (issue_ack_o) begin
      fu_data_q.op        <= issue_instr_i.op;
      fu_data_q.operand_a <= operand_a;
      fu_data_q.operand_b <= operand_b;
      fu_data_q.trans_id  <= issue_trans_id_i;
    end
  end

  assign fu_valid_o = fu_valid_q;
  assign fu_data_o  = fu_data_q;

  // A stalled instruction stays offered with the same slot until it dispatches
  a_offer_held: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    issue_valid_i && !issue_ack_o |=> issue_valid_i && $stable(issue_trans_id_i));

endmodule

// ==== design/issue_stage.sv ====
// Issue stage: scoreboard and operand read joined by the issue and forwarding buses
module issue_stage
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // Decode handshake
  input  logic                     instr_valid_i,
  input  decoded_instr_t           instr_i,
  output logic                     instr_ack_o,
  // Register file reads
  output logic [REG_ADDR_SIZE-1:0] rs1_o,
  output logic [REG_ADDR_SIZE-1:0] rs2_o,
  input  logic [XLEN-1:0]          rf_rdata1_i,
  input  logic [XLEN-1:0]          rf_rdata2_i,
  // ALU dispatch
  output logic                     fu_valid_o,
  output fu_data_t                 fu_data_o,
  // ALU writeback
  input  logic                     wb_valid_i,
  input  logic [TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [XLEN-1:0]          wb_data_i,
  // Commit
  output logic                     commit_valid_o,
  output logic [REG_ADDR_SIZE-1:0] commit_rd_o,
  output logic [XLEN-1:0]          commit_data_o,
  input  logic                     commit_ack_i
);

  // --------------------
  // Scoreboard <-> operand read
  // --------------------
  decoded_instr_t           issue_instr_sb_iro;
  logic [TRANS_ID_BITS-1:0] issue_trans_id_sb_iro;
  logic                     issue_valid_sb_iro;
  logic                     issue_ack_iro_sb;
  logic                     rs1_clobber_sb_iro;
  logic                     rs2_clobber_sb_iro;
  logic                     rs1_fwd_valid_sb_iro;
  logic                     rs2_fwd_valid_sb_iro;
  logic [XLEN-1:0]          rs1_fwd_sb_iro;
  logic [XLEN-1:0]          rs2_fwd_sb_iro;

  scoreboard i_scoreboard (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .instr_ack_o      (instr_ack_o),
    .issue_instr_o    (issue_instr_sb_iro),
    .issue_trans_id_o (issue_trans_id_sb_iro),
    .issue_valid_o    (issue_valid_sb_iro),
    .issue_ack_i      (issue_ack_iro_sb),
    // Lookup uses the same addresses as the register file
    .rs1_i            (rs1_o),
    .rs2_i            (rs2_o),
    .rs1_clobber_o    (rs1_clobber_sb_iro),
    .rs2_clobber_o    (rs2_clobber_sb_iro),
    .rs1_fwd_valid_o  (rs1_fwd_valid_sb_iro),
    .rs2_fwd_valid_o  (rs2_fwd_valid_sb_iro),
    .rs1_fwd_o        (rs1_fwd_sb_iro),
    .rs2_fwd_o        (rs2_fwd_sb_iro),
    .wb_valid_i       (wb_valid_i),
    .wb_trans_id_i    (wb_trans_id_i),
    .wb_data_i        (wb_data_i),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_ack_i     (commit_ack_i)
  );

  issue_read_operands i_issue_read_operands (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .issue_instr_i    (issue_instr_sb_iro),
    .issue_trans_id_i (issue_trans_id_sb_iro),
    .issue_valid_i    (issue_valid_sb_iro),
    .issue_ack_o      (issue_ack_iro_sb),
    .rs1_o            (rs1_o),
    .rs2_o            (rs2_o),
    .rs1_clobber_i    (rs1_clobber_sb_iro),
    .rs2_clobber_i    (rs2_clobber_sb_iro),
    .rs1_fwd_valid_i  (rs1_fwd_valid_sb_iro),
    .rs2_fwd_valid_i  (rs2_fwd_valid_sb_iro),
    .rs1_fwd_i        (rs1_fwd_sb_iro),
    .rs2_fwd_i        (rs2_fwd_sb_iro),
    .rf_rdata1_i      (rf_rdata1_i),
    .rf_rdata2_i      (rf_rdata2_i),
    .fu_valid_o       (fu_valid_o),
    .fu_data_o        (fu_data_o)
  );

endmodule

// ==== design/regfile.sv ====
// Architectural register file: two combinational reads, one write, r0 tied to zero
module regfile
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Read ports
  input  logic [REG_ADDR_SIZE-1:0] raddr1_i,
  input  logic [REG_ADDR_SIZE-1:0] raddr2_i,
  output logic [XLEN-1:0]          rdata1_o,
  output logic [XLEN-1:0]          rdata2_o,
  // Write port, driven by commit
  input  logic                     we_i,
  input  logic [REG_ADDR_SIZE-1:0] waddr_i,
  input  logic [XLEN-1:0]          wdata_i
);

  logic [XLEN-1:0] regs_q [NR_REGS];

  // Reset clears every register, r0 is never written afterwards
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int unsigned i = 0; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

// ==== design/scoreboard.sv ====
// Ring of in-flight instructions: accepts from decode, offers for issue, forwards and commits
module scoreboard
  import issue_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // Decode side
  input  logic                     instr_valid_i,
  input  decoded_instr_t           instr_i,
  output logic                     instr_ack_o,
  // Issue side
  output decoded_instr_t           issue_instr_o,
  output logic [TRANS_ID_BITS-1:0] issue_trans_id_o,
  output logic                     issue_valid_o,
  input  logic                     issue_ack_i,
  // Operand lookup
  input  logic [REG_ADDR_SIZE-1:0] rs1_i,
  input  logic [REG_ADDR_SIZE-1:0] rs2_i,
  output logic                     rs1_clobber_o,
  output logic                     rs2_clobber_o,
  output logic                     rs1_fwd_valid_o,
  output logic                     rs2_fwd_valid_o,
  output logic [XLEN-1:0]          rs1_fwd_o,
  output logic [XLEN-1:0]          rs2_fwd_o,
  // Writeback from the ALU
  input  logic                     wb_valid_i,
  input  logic [TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [XLEN-1:0]          wb_data_i,
  // In-order commit
  output logic                     commit_valid_o,
  output logic [REG_ADDR_SIZE-1:0] commit_rd_o,
  output logic [XLEN-1:0]          commit_data_o,
  input  logic                     commit_ack_i
);

  sb_entry_t                mem_q [NR_SB_ENTRIES];
  // Oldest entry, next entry to issue, next free slot
  logic [TRANS_ID_BITS-1:0] head_q;
  logic [TRANS_ID_BITS-1:0] issue_q;
  logic [TRANS_ID_BITS-1:0] tail_q;
  logic [SB_CNT_BITS-1:0]   count_q;
  logic [TRANS_ID_BITS-1:0] nr_older;
  logic                     full;
  logic                     accept;
  logic                     issue_fire;
  logic                     commit_fire;

  // --------------------
  // Handshakes
  // --------------------
  assign full        = (count_q == SB_CNT_BITS'(NR_SB_ENTRIES));
  assign instr_ack_o = instr_valid_i && !full && !flush_i;
  assign accept      = instr_ack_o;

  // Issue pointer equals tail either when nothing waits or when the ring is full
  assign issue_valid_o    = (count_q != '0) && ((issue_q != tail_q) || full)
                            && !mem_q[issue_q].issued;
  assign issue_instr_o    = mem_q[issue_q].instr;
  assign issue_trans_id_o = issue_q;
  assign issue_fire       = issue_valid_o && issue_ack_i;

  // Head commits once its result is back
  assign commit_valid_o = (count_q != '0) && mem_q[head_q].finished;
  assign commit_rd_o    = mem_q[head_q].instr.rd;
  assign commit_data_o  = mem_q[head_q].result;
  assign commit_fire    = commit_valid_o && commit_ack_i;

  // --------------------
  // Forwarding lookup
  // --------------------
  // Entries between head and the issue pointer are older than the one being issued
  assign nr_older = issue_q - head_q;

  always_comb begin
    logic [TRANS_ID_BITS-1:0] idx;
    idx             = head_q;
    rs1_clobber_o   = 1'b0;
    rs2_clobber_o   = 1'b0;
    rs1_fwd_valid_o = 1'b0;
    rs2_fwd_valid_o = 1'b0;
    rs1_fwd_o       = '0;
    rs2_fwd_o       = '0;
    // Walk oldest to youngest so the youngest writer wins
    for (int unsigned i = 0; i < NR_SB_ENTRIES; i++) begin
      idx = head_q + TRANS_ID_BITS'(i);
      if (TRANS_ID_BITS'(i) < nr_older) begin
        // r0 is never a real destination
        if (mem_q[idx].instr.rd == rs1_i && rs1_i != '0) begin
          rs1_clobber_o   = 1'b1;
          rs1_fwd_valid_o = mem_q[idx].finished;
          rs1_fwd_o       = mem_q[idx].result;
        end
        if (mem_q[idx].instr.rd == rs2_i && rs2_i != '0) begin
          rs2_clobber_o   = 1'b1;
          rs2_fwd_valid_o = mem_q[idx].finished;
          rs2_fwd_o       = mem_q[idx].result;
        end
      end
    end
  end

  // --------------------
  // Ring state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_q  <= '0;
      issue_q <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int unsigned i = 0; i < NR_SB_ENTRIES; i++) begin
        mem_q[i] <= '0;
      end
    end else if (flush_i) begin
      // Drop everything uncommitted, stale slots are rewritten on accept
      head_q  <= '0;
      issue_q <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (accept) begin
        mem_q[tail_q].instr    <= instr_i;
        mem_q[tail_q].issued   <= 1'b0;
        mem_q[tail_q].finished <= 1'b0;
        tail_q                 <= tail_q + 1'b1;
      end
      if (issue_fire) begin
        mem_q[issue_q].issued <= 1'b1;
        issue_q               <= issue_q + 1'b1;
      end
      // Writeback by transaction ID
      if (wb_valid_i) begin
        mem_q[wb_trans_id_i].finished <= 1'b1;
        mem_q[wb_trans_id_i].result   <= wb_data_i;
      end
      if (commit_fire) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + SB_CNT_BITS'(accept) - SB_CNT_BITS'(commit_fire);
    end
  end

  // --------------------
  // Checks
  // --------------------
  // A result coming back from the ALU must belong to an entry still waiting for it
  a_wb_target: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    wb_valid_i |-> mem_q[wb_trans_id_i].issued && !mem_q[wb_trans_id_i].finished);

  // The commit consumer only acks what is offered
  a_commit_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_ack_i |-> commit_valid_o);

endmodule

// ==== tests/tb_backend.sv ====
// Random-stimulus testbench for backend_top, checks every commit against an in-order model
module tb_backend
  import issue_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------
  // Test lengths
  // --------------------
  localparam int N_RANDOM     = 60;
  localparam int N_CHAIN      = 40;
  localparam int N_STALL      = 40;
  localparam int FILL_CYCLES  = 20;
  // Four fill the ring, one more waits with valid held high
  localparam int FILL_OFFERED = NR_SB_ENTRIES + 1;
  localparam int N_FILL_TAIL  = 4;
  localparam int N_FLUSH      = 30;
  localparam int FLUSH_AT     = 10;
  localparam int N_ZERO       = 20;
  localparam int N_TOTAL      = N_RANDOM + N_CHAIN + N_STALL + FILL_OFFERED + N_FILL_TAIL
                                + N_FLUSH + N_ZERO;
  localparam int unsigned TIMEOUT_CYCLES = N_TOTAL * 20 + 200;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] SEED = 32'd54846;

  // Stimulus flavours
  localparam int MODE_RANDOM = 0;
  localparam int MODE_CHAIN  = 1;
  localparam int MODE_ZERO   = 2;

  // DUT ports
  logic                     clk_i;
  logic                     rst_i;
  logic                     flush_i;
  logic                     instr_valid_i;
  alu_op_e                  instr_op_i;
  logic [REG_ADDR_SIZE-1:0] instr_rd_i;
  logic [REG_ADDR_SIZE-1:0] instr_rs1_i;
  logic [REG_ADDR_SIZE-1:0] instr_rs2_i;
  logic [IMM_BITS-1:0]      instr_imm_i;
  logic                     instr_use_imm_i;
  logic                     instr_ack_o;
  logic                     commit_valid_o;
  logic [REG_ADDR_SIZE-1:0] commit_rd_o;
  logic [XLEN-1:0]          commit_data_o;
  logic                     commit_ack_i;

  // Model and stimulus state
  decoded_instr_t           model_q [$];
  logic [XLEN-1:0]          model_regs [NR_REGS];
  decoded_instr_t           cur_instr;
  logic [REG_ADDR_SIZE-1:0] last_rd;
  logic [31:0]              rng_state;
  bit                       taken;
  int                       accept_total;
  // Commit offered but not yet acked, must stay put
  bit                       hold_seen;
  logic [REG_ADDR_SIZE-1:0] hold_rd;
  logic [XLEN-1:0]          hold_data;
  int unsigned              cycle_cnt;

  backend_top backend_top_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .instr_valid_i   (instr_valid_i),
    .instr_op_i      (instr_op_i),
    .instr_rd_i      (instr_rd_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_imm_i     (instr_imm_i),
    .instr_use_imm_i (instr_use_imm_i),
    .instr_ack_o     (instr_ack_o),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_data_o   (commit_data_o),
    .commit_ack_i    (commit_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog on the total cycle budget
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run hung and did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  // --------------------
  // Random numbers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Uniform 0..99
  function automatic int pct_roll();
    return int'(next_rand() % 100);
  endfunction

  function automatic decoded_instr_t make_instr(input int mode);
    decoded_instr_t ins;
    logic [31:0]    r;
    r           = next_rand();
    ins.op      = alu_op_e'(3'(r % 6));
    ins.rd      = r[10:8];
    ins.rs1     = r[13:11];
    ins.rs2     = r[16:14];
    ins.imm     = r[24:17];
    ins.use_imm = r[25];
    if (mode == MODE_CHAIN) begin
      // Read the previous destination so every step waits on the one before
      if (r[26]) begin
        ins.rs1 = last_rd;
      end else begin
        ins.rs2     = last_rd;
        ins.use_imm = 1'b0;
      end
      if (ins.rd == '0) begin
        ins.rd = REG_ADDR_SIZE'(1);
      end
    end else if (mode == MODE_ZERO) begin
      // Lots of r0 both as destination and as source
      ins.rd  = r[27] ? '0 : ins.rd;
      ins.rs1 = r[28] ? '0 : ins.rs1;
      ins.rs2 = r[29] ? '0 : ins.rs2;
    end
    last_rd = ins.rd;
    return ins;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  // Operands come from model registers, exact since commits are in order
  function automatic logic [XLEN-1:0] model_result(input decoded_instr_t ins);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = model_regs[ins.rs1];
    b = ins.use_imm ? XLEN'(ins.imm) : model_regs[ins.rs2];
    case (ins.op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[3:0];
      default: return '0;
    endcase
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic report_failure(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_commit_rd(input logic [REG_ADDR_SIZE-1:0] got,
                                 input logic [REG_ADDR_SIZE-1:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t: %s rd is %0d, expected %0d", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "commit rd mismatch");
    end
  endtask

  task automatic check_commit_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                   input string what);
    if (got !== exp) begin
      $display("FAIL at %0t: %s data is 0x%04h, expected 0x%04h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "commit data mismatch");
    end
  endtask

  // --------------------
  // Per-cycle drive and sample
  // --------------------
  // Called 1 ns after the rising edge
  task automatic drive_cycle(input int mode, input int gap_pct, input int stall_pct,
                             input bit allow_new, input bit flush_now, output bit created);
    created = 1'b0;
    if (taken) begin
      instr_valid_i = 1'b0;
      taken         = 1'b0;
    end
    // Source holds an offered instruction until it is acked
    if (!instr_valid_i && allow_new && pct_roll() >= gap_pct) begin
      cur_instr       = make_instr(mode);
      instr_op_i      = cur_instr.op;
      instr_rd_i      = cur_instr.rd;
      instr_rs1_i     = cur_instr.rs1;
      instr_rs2_i     = cur_instr.rs2;
      instr_imm_i     = cur_instr.imm;
      instr_use_imm_i = cur_instr.use_imm;
      instr_valid_i   = 1'b1;
      created         = 1'b1;
    end
    flush_i      = flush_now;
    commit_ack_i = commit_valid_o && !flush_now && (pct_roll() >= stall_pct);
  endtask

  // Inputs have been stable since 1 ns after the edge, so sample at the falling edge
  task automatic sample_cycle();
    decoded_instr_t  exp_instr;
    logic [XLEN-1:0] exp_data;
    @(negedge clk_i);
    if (flush_i) begin
      // Flush blocks acceptance in its own cycle
      if (instr_ack_o) begin
        report_failure("instr_ack_o was high during a flush");
      end
      model_q.delete();
      hold_seen = 1'b0;
    end else begin
      if (instr_valid_i && instr_ack_o) begin
        model_q.push_back(cur_instr);
        taken = 1'b1;
        accept_total++;
      end
      if (commit_valid_o) begin
        if (hold_seen) begin
          check_commit_rd(commit_rd_o, hold_rd, "stalled commit");
          check_commit_data(commit_data_o, hold_data, "stalled commit");
        end
        if (commit_ack_i) begin
          if (model_q.size() == 0) begin
            report_failure("a commit arrived with no accepted instruction outstanding");
          end
          exp_instr = model_q.pop_front();
          exp_data  = model_result(exp_instr);
          check_commit_rd(commit_rd_o, exp_instr.rd, "commit");
          check_commit_data(commit_data_o, exp_data, "commit");
          if (exp_instr.rd != '0) begin
            model_regs[exp_instr.rd] = exp_data;
          end
          hold_seen = 1'b0;
        end else begin
          hold_seen = 1'b1;
          hold_rd   = commit_rd_o;
          hold_data = commit_data_o;
        end
      end else if (hold_seen) begin
        report_failure("commit_valid_o dropped before the commit was acked");
      end
    end
  endtask

  // --------------------
  // Phases
  // --------------------
  // Offers n_instr instructions and runs until the model and the DUT are drained
  task automatic run_stream(input int n_instr, input int mode, input int gap_pct,
                            input int stall_pct, input int flush_at);
    int offered;
    int start_accepts;
    bit flushed;
    bit flush_now;
    bit created;
    offered       = 0;
    start_accepts = accept_total;
    flushed       = 1'b0;
    while (offered < n_instr || instr_valid_i || model_q.size() != 0) begin
      flush_now = (flush_at >= 0) && !flushed && (accept_total - start_accepts >= flush_at);
      if (flush_now) begin
        flushed = 1'b1;
      end
      drive_cycle(mode, gap_pct, stall_pct, offered < n_instr, flush_now, created);
      if (created) begin
        offered++;
      end
      sample_cycle();
      @(posedge clk_i);
      #1;
    end
    flush_i      = 1'b0;
    commit_ack_i = 1'b0;
  endtask

  // Commit held off on an empty ring, exactly four get in
  task automatic check_ring_fill();
    int start_accepts;
    bit created;
    start_accepts = accept_total;
    repeat (FILL_CYCLES) begin
      drive_cycle(MODE_RANDOM, 0, 100, 1'b1, 1'b0, created);
      sample_cycle();
      @(posedge clk_i);
      #1;
    end
    if (accept_total - start_accepts != NR_SB_ENTRIES) begin
      report_failure($sformatf("%0d instructions accepted with commit stalled, expected %0d",
                               accept_total - start_accepts, NR_SB_ENTRIES));
    end
    // Commits free the ring and the waiting instruction gets in
    run_stream(N_FILL_TAIL, MODE_RANDOM, 0, 0, -1);
  endtask

  initial begin
    rst_i           = 1'b1;
    flush_i         = 1'b0;
    instr_valid_i   = 1'b0;
    instr_op_i      = ALU_ADD;
    instr_rd_i      = '0;
    instr_rs1_i     = '0;
    instr_rs2_i     = '0;
    instr_imm_i     = '0;
    instr_use_imm_i = 1'b0;
    commit_ack_i    = 1'b0;
    rng_state       = SEED;
    last_rd         = REG_ADDR_SIZE'(1);
    taken           = 1'b0;
    accept_total    = 0;
    hold_seen       = 1'b0;
    cur_instr       = '0;
    for (int i = 0; i < NR_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    run_stream(N_RANDOM, MODE_RANDOM, 30, 30, -1);
    run_stream(N_CHAIN, MODE_CHAIN, 0, 0, -1);
    // Long commit stalls
    run_stream(N_STALL, MODE_RANDOM, 10, 75, -1);
    check_ring_fill();
    // Stalls build up a backlog for the flush to discard
    run_stream(N_FLUSH, MODE_RANDOM, 10, 50, FLUSH_AT);
    run_stream(N_ZERO, MODE_ZERO, 20, 20, -1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
